//--- apb_pkg.sv
package apb_pkg;

    // bus widths
    parameter int apb_addr_w = 8;
    parameter int apb_data_w = 32;

    // slave side of one transfer
    typedef enum logic [1:0] {
        phase_idle,   // waiting for psel and penable
        phase_access, // transfer accepted, pready goes out next
        phase_done    // pready seen, wait for penable to drop
    } apb_phase_e;

endpackage

//--- compile.f
+incdir+.
apb_pkg.sv
timer_pkg.sv
timer_channel.sv
timer_status.sv
timer_regs.sv
timer_periph.sv
timer_tb.sv

//--- run.sh
#!/bin/sh
# build the timer testbench with Verilator, run it, then look for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module timer_tb -o timer_sim \
    && ./obj_dir/timer_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q ">>> PASS" sim.log \
    && echo "timer simulation passed" \
    || { echo "timer simulation failed"; exit 1; }

//--- timer_channel.sv
`timescale 1ns/1ps

module timer_channel (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,
    input  timer_pkg::timer_mode_e mode,
    input  logic                   clear,
    input  logic [31:0]            psc,
    input  logic [31:0]            arr,
    output logic [31:0]            count,
    output logic                   wrap
);
    import timer_pkg::*;

    logic [31:0] psc_cnt;
    logic        held;   // one-shot has fired
    logic        tick;
    logic        at_top;

    // >= so a smaller psc or arr written mid-run still ends the period
    assign tick   = en && (psc_cnt >= psc);
    assign at_top = count >= arr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            psc_cnt <= '0;
            count   <= '0;
            held    <= 1'b0;
            wrap    <= 1'b0;
        end else begin
            wrap <= 1'b0;
            if (clear) begin
                psc_cnt <= '0;
                count   <= '0;
                held    <= 1'b0;
            end else begin
                if (en) begin
                    psc_cnt <= tick ? '0 : psc_cnt + 32'd1;
                end
                if (mode == mode_periodic) begin
                    held <= 1'b0;
                end

                if (tick) begin
                    if (!at_top) begin
                        count <= count + 32'd1;
                    end else if (mode == mode_periodic) begin
                        count <= '0;
                        wrap  <= 1'b1;
                    end else if (!held) begin
                        count <= arr; // park at the top
                        held  <= 1'b1;
                        wrap  <= 1'b1;
                    end
                end
            end
        end
    end

    // once inside arr the count stays there while arr is unchanged
    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        ($past(count <= arr) && $stable(arr)) |-> (count <= arr));

endmodule

//--- timer_periph.sv
`timescale 1ns/1ps

module timer_periph #(
    parameter int NUM_CH = timer_pkg::default_num_ch
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [apb_pkg::apb_addr_w-1:0] paddr,
    input  logic [apb_pkg::apb_data_w-1:0] pwdata,
    input  logic                           pwrite,
    input  logic                           psel,
    input  logic                           penable,
    output logic [apb_pkg::apb_data_w-1:0] prdata,
    output logic                           pready,
    output logic                           irq
);
    import timer_pkg::*;

    logic [NUM_CH-1:0] ch_en;
    timer_mode_e       ch_mode [NUM_CH];
    logic [NUM_CH-1:0] ch_clear;
    logic [31:0]       ch_psc [NUM_CH];
    logic [31:0]       ch_arr [NUM_CH];
    logic [31:0]       ch_count [NUM_CH];
    logic [NUM_CH-1:0] ch_wrap;
    logic [NUM_CH-1:0] status_clr;
    logic              mask_we;
    logic [NUM_CH-1:0] mask_wdata;
    logic [NUM_CH-1:0] status;
    logic [NUM_CH-1:0] mask;

    timer_regs #(.NUM_CH(NUM_CH)) i_regs (
        .clk        (clk),
        .reset      (reset),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pwrite     (pwrite),
        .psel       (psel),
        .penable    (penable),
        .prdata     (prdata),
        .pready     (pready),
        .ch_en      (ch_en),
        .ch_mode    (ch_mode),
        .ch_clear   (ch_clear),
        .ch_psc     (ch_psc),
        .ch_arr     (ch_arr),
        .ch_count   (ch_count),
        .status_clr (status_clr),
        .mask_we    (mask_we),
        .mask_wdata (mask_wdata),
        .status     (status),
        .mask       (mask)
    );

    for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
        timer_channel i_channel (
            .clk   (clk),
            .reset (reset),
            .en    (ch_en[g]),
            .mode  (ch_mode[g]),
            .clear (ch_clear[g]),
            .psc   (ch_psc[g]),
            .arr   (ch_arr[g]),
            .count (ch_count[g]),
            .wrap  (ch_wrap[g])
        );
    end

    timer_status #(.NUM_CH(NUM_CH)) i_status (
        .clk        (clk),
        .reset      (reset),
        .wrap       (ch_wrap),
        .status_clr (status_clr),
        .mask_we    (mask_we),
        .mask_wdata (mask_wdata),
        .status     (status),
        .mask       (mask),
        .irq        (irq)
    );

endmodule

//--- timer_pkg.sv
package timer_pkg;

    // each channel owns a 16 byte block starting at 0x00
    parameter int ch_stride = 16;

    // offsets inside a channel block
    parameter int off_ctrl  = 0;
    parameter int off_count = 4; // read only
    parameter int off_psc   = 8;
    parameter int off_arr   = 12;

    // global registers, above the last possible channel block
    parameter int addr_status = 'h80;
    parameter int addr_mask   = 'h84;

    // ctrl word fields
    parameter int ctrl_en_bit    = 0;
    parameter int ctrl_clear_bit = 1; // pulse only, reads back zero
    parameter int ctrl_mode_bit  = 2;

    typedef enum logic {
        mode_periodic = 1'b0,
        mode_oneshot  = 1'b1
    } timer_mode_e;

    parameter int default_num_ch = 4;

endpackage

//--- timer_regs.sv
`timescale 1ns/1ps

module timer_regs #(
    parameter int NUM_CH = timer_pkg::default_num_ch
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [apb_pkg::apb_addr_w-1:0] paddr,
    input  logic [apb_pkg::apb_data_w-1:0] pwdata,
    input  logic                           pwrite,
    input  logic                           psel,
    input  logic                           penable,
    output logic [apb_pkg::apb_data_w-1:0] prdata,
    output logic                           pready,
    output logic [NUM_CH-1:0]              ch_en,
    output timer_pkg::timer_mode_e         ch_mode [NUM_CH],
    output logic [NUM_CH-1:0]              ch_clear,
    output logic [31:0]                    ch_psc [NUM_CH],
    output logic [31:0]                    ch_arr [NUM_CH],
    input  logic [31:0]                    ch_count [NUM_CH],
    output logic [NUM_CH-1:0]              status_clr,
    output logic                           mask_we,
    output logic [NUM_CH-1:0]              mask_wdata,
    input  logic [NUM_CH-1:0]              status,
    input  logic [NUM_CH-1:0]              mask
);
    import apb_pkg::*;
    import timer_pkg::*;

    apb_phase_e            phase;
    logic [apb_addr_w-1:0] sel_ch;
    logic [apb_addr_w-1:0] sel_off;
    logic                  ch_hit;
    logic                  wr_hit;
    logic [apb_data_w-1:0] rd_data;

    assign sel_ch  = paddr / apb_addr_w'(ch_stride);
    assign sel_off = paddr % apb_addr_w'(ch_stride);
    assign ch_hit  = int'(sel_ch) < NUM_CH;
    assign wr_hit  = (phase == phase_access) && pwrite;

    // global writes land on the same edge as pready
    assign status_clr = (wr_hit && int'(paddr) == addr_status) ? pwdata[NUM_CH-1:0] : '0;
    assign mask_we    = wr_hit && int'(paddr) == addr_mask;
    assign mask_wdata = pwdata[NUM_CH-1:0];

    always_comb begin
        rd_data = '0;
        if (int'(paddr) == addr_status) begin
            rd_data[NUM_CH-1:0] = status;
        end else if (int'(paddr) == addr_mask) begin
            rd_data[NUM_CH-1:0] = mask;
        end else if (ch_hit) begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (int'(sel_ch) == i) begin
                    case (int'(sel_off))
                        off_ctrl: begin
                            rd_data[ctrl_en_bit]   = ch_en[i];
                            rd_data[ctrl_mode_bit] = (ch_mode[i] == mode_oneshot);
                        end
                        off_count: rd_data = ch_count[i];
                        off_psc:   rd_data = ch_psc[i];
                        off_arr:   rd_data = ch_arr[i];
                        default:   rd_data = '0; // hole inside the block
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase    <= phase_idle;
            pready   <= 1'b0;
            prdata   <= '0;
            ch_en    <= '0;
            ch_clear <= '0;
            for (int i = 0; i < NUM_CH; i++) begin
                ch_mode[i] <= mode_periodic;
                ch_psc[i]  <= '0;
                ch_arr[i]  <= '0;
            end
        end else begin
            pready   <= 1'b0;
            ch_clear <= '0; // clear lasts one cycle only
            case (phase)
                phase_idle: begin
                    if (psel && penable) phase <= phase_access;
                end
                phase_access: begin
                    pready <= 1'b1;
                    phase  <= phase_done;
                    if (!pwrite) prdata <= rd_data;
                    for (int i = 0; i < NUM_CH; i++) begin
                        if (pwrite && ch_hit && int'(sel_ch) == i) begin
                            case (int'(sel_off))
                                off_ctrl: begin
                                    ch_en[i]    <= pwdata[ctrl_en_bit];
                                    ch_mode[i]  <= timer_mode_e'(pwdata[ctrl_mode_bit]);
                                    ch_clear[i] <= pwdata[ctrl_clear_bit];
                                end
                                off_psc: ch_psc[i] <= pwdata;
                                off_arr: ch_arr[i] <= pwdata;
                                default: ; // count and holes ignore writes
                            endcase
                        end
                    end
                end
                phase_done: begin
                    if (!penable) phase <= phase_idle;
                end
                default: phase <= phase_idle;
            endcase
        end
    end

    a_pready_one_cycle: assert property (@(posedge clk) disable iff (reset)
        pready |=> !pready);

    // master must still hold psel when ready comes back
    a_pready_in_psel: assert property (@(posedge clk) disable iff (reset)
        pready |-> psel);

endmodule

//--- timer_status.sv
`timescale 1ns/1ps

module timer_status #(
    parameter int NUM_CH = timer_pkg::default_num_ch
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [NUM_CH-1:0] wrap,
    input  logic [NUM_CH-1:0] status_clr,
    input  logic              mask_we,
    input  logic [NUM_CH-1:0] mask_wdata,
    output logic [NUM_CH-1:0] status,
    output logic [NUM_CH-1:0] mask,
    output logic              irq
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status <= '0;
        end else begin
            // a wrap in the same cycle beats the clear
            status <= (status & ~status_clr) | wrap;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mask <= '0;
        end else if (mask_we) begin
            mask <= mask_wdata;
        end
    end

    assign irq = |(status & mask);

    // irq only rises after a channel wrap or a mask write,
    // and never without a pending status bit
    a_irq_source: assert property (@(posedge clk) disable iff (reset)
        $rose(irq) |-> (status != '0) && $past(|wrap || mask_we));

endmodule

//--- timer_tb_apb.svh
task automatic apb_transfer(input logic write, input int addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    paddr  <= 8'(addr);
    pwdata <= wdata;
    pwrite <= write;
    psel   <= 1'b1; // setup cycle
    @(posedge clk);
    penable <= 1'b1;
    do begin
        @(negedge clk);
        waited++;
    end while (!pready && waited < 20);
    checks++;
    assert (pready && waited == 3) else begin
        errors++;
        $display("pready came %0d cycles after penable at address 0x%02h instead of 2",
                 waited - 1, addr);
    end
    rdata = prdata;
    if (write && addr == addr_mask) begin
        mask_model = wdata[num_ch-1:0]; // mask takes the write along with pready
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

task automatic apb_write(input int addr, input logic [31:0] data);
    logic [31:0] ignored;
    apb_transfer(1'b1, addr, data, ignored);
endtask

task automatic apb_read(input int addr, output logic [31:0] data);
    apb_transfer(1'b0, addr, 32'h0, data);
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
        errors++;
        $display("error %s got 0x%08h expected 0x%08h", name, got, exp);
    end
endtask

task automatic check_not_above(input string name, input logic [31:0] got,
                               input logic [31:0] limit);
    checks++;
    assert (got <= limit) else begin
        errors++;
        $display("error %s 0x%08h above limit 0x%08h", name, got, limit);
    end
endtask

function automatic logic [31:0] ctrl_word(input logic en, input logic oneshot, input logic clear);
    logic [31:0] w;
    w = '0;
    w[ctrl_en_bit]    = en;
    w[ctrl_mode_bit]  = oneshot;
    w[ctrl_clear_bit] = clear;
    return w;
endfunction

// only en and mode survive in the ctrl register
function automatic logic [31:0] ctrl_kept(input logic [31:0] word);
    return word & ctrl_word(1'b1, 1'b1, 1'b0);
endfunction

// enabled cycles from enable to the first wrap
function automatic int wrap_period(input logic [31:0] psc_v, input logic [31:0] arr_v);
    return (int'(psc_v) + 1) * (int'(arr_v) + 1);
endfunction

function automatic int ch_addr(input int ch, input int off);
    return ch * ch_stride + off;
endfunction

// poll status until a bit sets or the cycle limit runs out
task automatic wait_status(input int bit_idx, input int limit, output logic [31:0] st);
    int start;
    start = cycle;
    do begin
        apb_read(addr_status, st);
    end while (!st[bit_idx] && cycle - start < limit);
endtask

//--- timer_tb.sv
`timescale 1ns/1ps

module timer_tb;
    import apb_pkg::*;
    import timer_pkg::*;

    localparam int num_ch = 4;

    logic                  clk = 1'b0;
    logic                  reset;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    logic                  pwrite;
    logic                  psel;
    logic                  penable;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  irq;

    int          errors = 0;
    int          checks = 0;
    int          cycle  = 0;
    int          budget = 0;
    int          holes [4] = '{'h02, 'h40, 'h7c, 'h88};
    logic [31:0] rd;
    logic [31:0] rd2;
    logic [31:0] word;
    logic [31:0] psc [num_ch];
    logic [31:0] arr [num_ch];
    logic [num_ch-1:0] mask_model = '0; // mask as written over the bus

    `include "timer_tb_apb.svh"

    timer_periph #(.NUM_CH(num_ch)) i_dut (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pwrite  (pwrite),
        .psel    (psel),
        .penable (penable),
        .prdata  (prdata),
        .pready  (pready),
        .irq     (irq)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    a_ready_in_access: assert property (@(posedge clk) disable iff (reset)
        pready |-> psel && penable && i_dut.i_regs.phase == phase_done) else begin
        errors++;
        $display("error pready 0x%h with psel 0x%h penable 0x%h", pready, psel, penable);
    end

    // one wait state before ready
    a_ready_wait: assert property (@(posedge clk) disable iff (reset)
        $rose(psel && penable) |=> !pready) else begin
        errors++;
        $display("error pready 0x%h one cycle after access start", pready);
    end

    a_irq_equation: assert property (@(posedge clk) disable iff (reset)
        irq == |(i_dut.status & mask_model)) else begin
        errors++;
        $display("error irq 0x%h expected 0x%h", irq, |(i_dut.status & mask_model));
    end

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", budget);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        void'($urandom(10642));
        reset   = 1'b1;
        paddr   = '0;
        pwdata  = '0;
        pwrite  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        for (int i = 0; i < num_ch; i++) begin
            psc[i] = $urandom_range(3, 0);
            arr[i] = $urandom_range(7, 1);
            budget += 4 * wrap_period(psc[i], arr[i]);
        end
        budget += 2500; // register traffic and polling
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // read-back, huge prescaler keeps counters still
        for (int ch = 0; ch < num_ch; ch++) begin
            word = $urandom | 32'h8000_0000;
            apb_write(ch_addr(ch, off_psc), word);
            apb_read(ch_addr(ch, off_psc), rd);
            check_word("psc", rd, word);
            word = $urandom;
            apb_write(ch_addr(ch, off_arr), word);
            apb_read(ch_addr(ch, off_arr), rd);
            check_word("arr", rd, word);
            word = $urandom;
            apb_write(ch_addr(ch, off_ctrl), word);
            apb_read(ch_addr(ch, off_ctrl), rd);
            check_word("ctrl", rd, ctrl_kept(word));
        end
        word = $urandom;
        apb_write(addr_mask, word);
        apb_read(addr_mask, rd);
        check_word("mask", rd, word & ((32'd1 << num_ch) - 1));
        foreach (holes[i]) begin
            apb_read(holes[i], rd);
            check_word("prdata", rd, 32'h0);
        end
        for (int ch = 0; ch < num_ch; ch++) begin
            apb_write(ch_addr(ch, off_ctrl), ctrl_word(1'b0, 1'b0, 1'b1));
        end
        apb_write(addr_mask, 32'h0);

        // periodic wrap on channel 0
        apb_write(ch_addr(0, off_psc), psc[0]);
        apb_write(ch_addr(0, off_arr), arr[0]);
        apb_write(ch_addr(0, off_ctrl), ctrl_word(1'b1, 1'b0, 1'b0));
        wait_status(0, wrap_period(psc[0], arr[0]) + 8, rd);
        check_word("status", rd & 32'h1, 32'h1);
        repeat (6) begin
            apb_read(ch_addr(0, off_count), rd);
            check_not_above("count", rd, arr[0]);
        end
        apb_write(ch_addr(0, off_ctrl), 32'h0);
        apb_write(addr_status, 32'h1);
        apb_read(addr_status, rd);
        check_word("status", rd, 32'h0);

        // one-shot on channel 1
        apb_write(ch_addr(1, off_psc), psc[1]);
        apb_write(ch_addr(1, off_arr), arr[1]);
        apb_write(ch_addr(1, off_ctrl), ctrl_word(1'b1, 1'b1, 1'b0));
        wait_status(1, wrap_period(psc[1], arr[1]) + 8, rd);
        check_word("status", rd & 32'h2, 32'h2);
        repeat (3) begin
            apb_read(ch_addr(1, off_count), rd);
            check_word("count", rd, arr[1]);
        end
        apb_write(addr_status, 32'h2);
        repeat (2 * wrap_period(psc[1], arr[1]) + 4) @(posedge clk); // no second wrap
        apb_read(addr_status, rd);
        check_word("status", rd, 32'h0);
        apb_write(ch_addr(1, off_ctrl), ctrl_word(1'b1, 1'b1, 1'b1));
        wait_status(1, wrap_period(psc[1], arr[1]) + 8, rd);
        check_word("status", rd & 32'h2, 32'h2);
        apb_write(ch_addr(1, off_ctrl), 32'h0);
        apb_write(addr_status, 32'h2);

        // status and mask, only channel 2 unmasked
        apb_write(addr_mask, 32'h4);
        for (int ch = 2; ch < 4; ch++) begin
            apb_write(ch_addr(ch, off_psc), psc[ch]);
            apb_write(ch_addr(ch, off_arr), arr[ch]);
            apb_write(ch_addr(ch, off_ctrl), ctrl_word(1'b1, 1'b0, 1'b0));
        end
        wait_status(3, wrap_period(psc[3], arr[3]) + 8, rd);
        wait_status(2, wrap_period(psc[2], arr[2]) + 8, rd);
        apb_write(ch_addr(2, off_ctrl), 32'h0);
        apb_write(ch_addr(3, off_ctrl), 32'h0);
        apb_read(addr_status, rd);
        check_word("status", rd, 32'hc);
        apb_read(addr_mask, rd2);
        @(negedge clk);
        check_word("irq", 32'(irq), 32'(|(rd & rd2)));
        apb_write(addr_status, 32'h4);
        apb_read(addr_status, rd);
        check_word("status", rd, 32'h8);
        @(negedge clk);
        check_word("irq", 32'(irq), 32'(|(rd & rd2))); // masked channel alone
        apb_write(addr_status, 32'h8);
        apb_read(addr_status, rd);
        check_word("status", rd, 32'h0);

        // disable holds the count, clear zeroes it
        apb_write(ch_addr(0, off_psc), 32'h0);
        apb_write(ch_addr(0, off_arr), 32'hffff);
        apb_write(ch_addr(0, off_ctrl), ctrl_word(1'b1, 1'b0, 1'b0));
        repeat (20) @(posedge clk);
        apb_write(ch_addr(0, off_ctrl), 32'h0);
        apb_read(ch_addr(0, off_count), rd);
        repeat (10) @(posedge clk);
        apb_read(ch_addr(0, off_count), rd2);
        check_word("count", rd2, rd);
        apb_write(ch_addr(0, off_ctrl), ctrl_word(1'b0, 1'b0, 1'b1));
        apb_read(ch_addr(0, off_count), rd);
        check_word("count", rd, 32'h0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
